// ==== Makefile ====
# Verilator build and run of the KD-tree search core testbench

TOP := kd_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== sim.f ====
+incdir+testbench
verilog/kd_pkg.sv
verilog/kd_internal_node.sv
verilog/kd_node_tree.sv
verilog/kd_cfg_port.sv
verilog/kd_search_top.sv
testbench/kd_tb.sv

// ==== testbench/kd_tb_ref.svh ====
//////////////////////////////////////////////////
// KD-tree testbench reference model
// Node word mirror, expected leaf walk, checks
//////////////////////////////////////////////////

`ifndef KD_TB_REF_SVH
`define KD_TB_REF_SVH

kd_pkg::kd_node_t model [kd_pkg::KD_NODES];  // Mirror of the node words, heap order

// Stop the run with a reason in plain words
task automatic abort_run(input string why);
  $display("%s", why);
  $display("Simulation finished: FAIL");
  $fatal(1, "Run stopped");
endtask

// Compare one value, first mismatch ends the run
task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    $display("ERROR %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
    $display("Simulation finished: FAIL");
    $fatal(1, "Value mismatch");
  end
endtask

// Walk the mirrored tree from the root, one decision per level
function automatic logic [kd_pkg::KD_ADDR_W-1:0] kd_ref_leaf(input kd_pkg::kd_patch_t p);
  logic [kd_pkg::KD_PATCH_W-1:0] flat;
  logic [kd_pkg::KD_COORD_W-1:0] c;
  logic [kd_pkg::KD_ADDR_W-1:0]  leaf;
  logic                          right;
  int                            n;
  int                            dim;
  flat = p;
  leaf = '0;
  n    = 0;                        // Root
  for (int lvl = 0; lvl < kd_pkg::KD_DEPTH; lvl++) begin
    dim   = int'(model[n].split);  // Only legal dims are ever written
    c     = kd_pkg::KD_COORD_W'(flat >> (dim * kd_pkg::KD_COORD_W));  // Coord 0 lowest
    right = (c >= model[n].median);  // Ties go right
    leaf  = {leaf[kd_pkg::KD_ADDR_W-2:0], right};  // Root decision ends up in the MSB
    n     = 2 * n + 1 + int'(right);
  end
  return leaf;
endfunction

// Random node word with a legal split dimension
function automatic kd_pkg::kd_node_t rand_node();
  kd_pkg::kd_node_t w;
  w.split  = kd_pkg::KD_COORD_W'($urandom_range(kd_pkg::KD_DIMS - 1));
  w.median = kd_pkg::KD_COORD_W'($urandom_range(2047));
  return w;
endfunction

function automatic kd_pkg::kd_patch_t rand_patch();
  kd_pkg::kd_patch_t p;
  for (int d = 0; d < kd_pkg::KD_DIMS; d++) begin
    p.coord[d] = kd_pkg::KD_COORD_W'($urandom_range(2047));
  end
  return p;
endfunction

`endif

// ==== testbench/kd_tb.sv ====
//////////////////////////////////////////////////
// KD-tree search core testbench
// Stream and bus loading, two-lane random search
// against the reference walk, per-lane scoreboard
//////////////////////////////////////////////////

module kd_tb;

  localparam int TIMEOUT_CYC = 6000;  // About twice the full test length

  logic               clk;
  logic               rst_n;
  logic               load_valid;
  kd_pkg::kd_node_t   load_data;
  logic               bus_cyc;
  logic               bus_stb;
  logic               bus_we;
  logic [6:0]         bus_adr;
  logic [31:0]        bus_dat_w;
  logic               bus_ack;
  logic [31:0]        bus_dat_r;
  kd_pkg::kd_query_t  query_a;
  kd_pkg::kd_query_t  query_b;
  kd_pkg::kd_result_t result_a;
  kd_pkg::kd_result_t result_b;

  int          cyc = 0;       // Free-running, also the issue timestamp
  int          load_ptr = 0;  // Expected stream counter
  int          sent_a = 0;
  int          sent_b = 0;
  int          got_a = 0;
  int          got_b = 0;
  logic [31:0] exp_a [$];     // {issue cycle, leaf}
  logic [31:0] exp_b [$];

  `include "kd_tb_ref.svh"

  kd_search_top i_kd_search_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_valid_i (load_valid),
    .load_data_i  (load_data),
    .bus_cyc_i    (bus_cyc),
    .bus_stb_i    (bus_stb),
    .bus_we_i     (bus_we),
    .bus_adr_i    (bus_adr),
    .bus_dat_i    (bus_dat_w),
    .bus_ack_o    (bus_ack),
    .bus_dat_o    (bus_dat_r),
    .query_a_i    (query_a),
    .query_b_i    (query_b),
    .result_a_o   (result_a),
    .result_b_o   (result_b)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      abort_run("Timeout, the tests did not finish within the cycle limit");
    end
  end

  // Leaf and latency of one result against its queue entry
  task automatic check_result(input string name, input kd_pkg::kd_result_t res,
                              input logic [31:0] entry);
    check_val({name, ".leaf"}, 32'(entry[5:0]), 32'(res.leaf));
    check_val({name, " latency"}, 32'(kd_pkg::KD_DEPTH), 32'(cyc - int'(entry[31:6])));
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n && result_a.valid) begin
      if (exp_a.size() == 0) begin
        abort_run("Lane A gave a result with no query in flight");
      end else begin
        check_result("result_a_o", result_a, exp_a.pop_front());
        got_a++;
      end
    end
    if (rst_n && result_b.valid) begin
      if (exp_b.size() == 0) begin
        abort_run("Lane B gave a result with no query in flight");
      end else begin
        check_result("result_b_o", result_b, exp_b.pop_front());
        got_b++;
      end
    end
  end

  task automatic do_reset();
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    load_ptr = 0;
    for (int k = 0; k < kd_pkg::KD_NODES; k++) begin
      model[k] = '0;  // Nodes clear on reset
    end
  endtask

  // One word per cycle, counter wraps after node 62
  task automatic stream_load(input int count);
    kd_pkg::kd_node_t w;
    for (int k = 0; k < count; k++) begin
      w               = rand_node();
      load_valid      = 1'b1;
      load_data       = w;
      model[load_ptr] = w;
      load_ptr        = (load_ptr == kd_pkg::KD_NODES - 1) ? 0 : load_ptr + 1;
      @(posedge clk);
      #1;
    end
    load_valid = 1'b0;
  endtask

  // Hold the request until ack, drop it the cycle after
  task automatic bus_access(input logic we, input logic [6:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    bus_cyc   = 1'b1;
    bus_stb   = 1'b1;
    bus_we    = we;
    bus_adr   = adr;
    bus_dat_w = wdat;
    @(negedge clk);
    while (!bus_ack) @(negedge clk);
    rdat = bus_dat_r;  // Read data valid with ack
    @(posedge clk);
    #1;
    bus_cyc = 1'b0;
    bus_stb = 1'b0;
    bus_we  = 1'b0;
  endtask

  // Read both halves of a node, address 63 reads as zero
  task automatic check_node(input int n);
    logic [31:0]      rd;
    kd_pkg::kd_node_t exp_w;
    exp_w = '0;
    if (n < kd_pkg::KD_NODES) begin
      exp_w = model[n];
    end
    bus_access(1'b0, {kd_pkg::KD_HALF_SPLIT, 6'(n)}, '0, rd);
    check_val($sformatf("bus_dat_o split node %0d", n), 32'(exp_w.split), rd);
    bus_access(1'b0, {kd_pkg::KD_HALF_MEDIAN, 6'(n)}, '0, rd);
    check_val($sformatf("bus_dat_o median node %0d", n), 32'(exp_w.median), rd);
  endtask

  task automatic run_queries(input int ncyc, input int pct_a, input int pct_b);
    for (int k = 0; k < ncyc; k++) begin
      query_a.valid = ($urandom_range(99) < pct_a);
      query_a.patch = rand_patch();
      query_b.valid = ($urandom_range(99) < pct_b);
      query_b.patch = rand_patch();
      if (query_a.valid) begin
        exp_a.push_back({cyc[25:0], kd_ref_leaf(query_a.patch)});
        sent_a++;
      end
      if (query_b.valid) begin
        exp_b.push_back({cyc[25:0], kd_ref_leaf(query_b.patch)});
        sent_b++;
      end
      @(posedge clk);
      #1;
    end
    query_a.valid = 1'b0;
    query_b.valid = 1'b0;
  endtask

  // Last result trails the last query by the fixed search latency
  task automatic wait_drain();
    repeat (kd_pkg::KD_DEPTH + 1) begin
      @(posedge clk);
      #1;
    end
    check_val("result_a_o count", 32'(sent_a), 32'(got_a));
    check_val("result_b_o count", 32'(sent_b), 32'(got_b));
  endtask

  initial begin
    logic [31:0]      rd;
    kd_pkg::kd_node_t w;
    int               n;

    void'($urandom(22));  // One seed for the whole run
    rst_n      = 1'b0;
    load_valid = 1'b0;
    load_data  = '0;
    bus_cyc    = 1'b0;
    bus_stb    = 1'b0;
    bus_we     = 1'b0;
    bus_adr    = '0;
    bus_dat_w  = '0;
    query_a    = '0;
    query_b    = '0;
    do_reset();

    @(negedge clk);  // Idle outputs after reset
    check_val("result_a_o.valid", 32'(0), 32'(result_a.valid));
    check_val("result_b_o.valid", 32'(0), 32'(result_b.valid));
    check_val("bus_ack_o", 32'(0), 32'(bus_ack));
    @(posedge clk);
    #1;
    check_node(0);

    stream_load(kd_pkg::KD_NODES);
    for (int k = 0; k < kd_pkg::KD_NODES; k++) begin
      check_node(k);
    end

    run_queries(1, 100, 0);  // Single lane A query, lane B stays idle
    wait_drain();
    run_queries(1000, 50, 50);
    wait_drain();

    for (int k = 0; k < 32; k++) begin
      n = $urandom_range(kd_pkg::KD_NODES - 1);
      w = rand_node();
      bus_access(1'b1, {kd_pkg::KD_HALF_MEDIAN, 6'(n)}, 32'(w.median), rd);
      check_node(n);  // Median only staged so far
      bus_access(1'b1, {kd_pkg::KD_HALF_SPLIT, 6'(n)}, 32'(w.split), rd);
      model[n] = w;
      check_node(n);
    end
    bus_access(1'b1, {kd_pkg::KD_HALF_MEDIAN, 6'd63}, 32'h5a5, rd);
    bus_access(1'b1, {kd_pkg::KD_HALF_SPLIT, 6'd63}, 32'h2, rd);
    for (int k = 0; k <= kd_pkg::KD_NODES; k++) begin
      check_node(k);  // Last one is address 63
    end
    run_queries(500, 60, 60);
    wait_drain();

    stream_load(5);  // Leave the counter mid-tree
    do_reset();
    stream_load(3);
    for (int k = 0; k < 4; k++) begin
      check_node(k);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== verilog/kd_cfg_port.sv ====
//////////////////////////////////////////////////
// KD-tree configuration port
// Stream loader and Wishbone-style slave that
// turn writes into node updates and serve reads
//////////////////////////////////////////////////

module kd_cfg_port (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load_valid_i,
  input  kd_pkg::kd_node_t             load_data_i,
  input  logic                         bus_cyc_i,
  input  logic                         bus_stb_i,
  input  logic                         bus_we_i,
  input  logic [6:0]                   bus_adr_i,   // [6] half, [5:0] node
  input  logic [31:0]                  bus_dat_i,
  output logic                         bus_ack_o,
  output logic [31:0]                  bus_dat_o,
  output kd_pkg::kd_node_wr_t          node_wr_o,
  output logic [kd_pkg::KD_ADDR_W-1:0] node_rd_addr_o,
  input  kd_pkg::kd_node_t             node_rd_i
);

  logic [kd_pkg::KD_ADDR_W-1:0]  load_cnt_q;    // Next node for the stream
  logic [kd_pkg::KD_COORD_W-1:0] median_q;      // Staged median half
  logic                          ack_q;
  logic [31:0]                   rdat_q;

  kd_pkg::kd_half_e              bus_half;
  logic [kd_pkg::KD_ADDR_W-1:0]  bus_node;
  logic                          bus_node_ok;   // Not address 63
  logic                          bus_accept;
  logic                          bus_commit;
  logic                          load_wr;

  assign bus_half    = kd_pkg::kd_half_e'(bus_adr_i[6]);
  assign bus_node    = bus_adr_i[kd_pkg::KD_ADDR_W-1:0];
  assign bus_node_ok = (bus_node < kd_pkg::KD_NODES);

  // Take only the first cycle of a held request
  assign bus_accept = bus_cyc_i & bus_stb_i & ~ack_q;
  assign bus_commit = bus_accept & bus_we_i & (bus_half == kd_pkg::KD_HALF_SPLIT) & bus_node_ok;

  // Bus commit beats the stream, the stream word is lost
  assign load_wr = load_valid_i & ~bus_commit;

  always_comb begin
    node_wr_o = '0;
    if (bus_commit) begin
      node_wr_o.en          = 1'b1;
      node_wr_o.addr        = bus_node;
      node_wr_o.node.split  = bus_dat_i[kd_pkg::KD_COORD_W-1:0];
      node_wr_o.node.median = median_q;   // Held from the earlier median write
    end else if (load_wr) begin
      node_wr_o.en   = 1'b1;
      node_wr_o.addr = load_cnt_q;
      node_wr_o.node = load_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_cnt_q <= '0;
    end else if (load_wr) begin
      if (load_cnt_q == kd_pkg::KD_ADDR_W'(kd_pkg::KD_NODES - 1)) begin
        load_cnt_q <= '0;  // Wrap after node 62
      end else begin
        load_cnt_q <= load_cnt_q + 1'b1;
      end
    end
  end

  // Median half only stages, nothing reaches the tree yet
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      median_q <= '0;
    end else if (bus_accept && bus_we_i && bus_node_ok &&
                 (bus_half == kd_pkg::KD_HALF_MEDIAN)) begin
      median_q <= bus_dat_i[kd_pkg::KD_COORD_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_accept;  // One-cycle pulse, writes to 63 ack too
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge clk) begin
    if (bus_accept && !bus_we_i) begin
      if (bus_half == kd_pkg::KD_HALF_SPLIT) begin
        rdat_q <= 32'(node_rd_i.split);
      end else begin
        rdat_q <= 32'(node_rd_i.median);
      end
    end
  end

  assign node_rd_addr_o = bus_node;   // Tree returns 0 for address 63
  assign bus_ack_o      = ack_q;
  assign bus_dat_o      = rdat_q;

endmodule

// ==== verilog/kd_internal_node.sv ====
//////////////////////////////////////////////////
// KD-tree internal node
// Holds one split word and steers the one-hot
// valid of each lane to its left or right child
//////////////////////////////////////////////////

module kd_internal_node (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en_i,    // Decoded write enable for this node
  input  kd_pkg::kd_node_t  wdata_i,
  input  logic              valid_a_i,
  input  logic              valid_b_i,
  input  kd_pkg::kd_patch_t patch_a_i,
  input  kd_pkg::kd_patch_t patch_b_i,
  output logic              left_a_o,
  output logic              right_a_o,
  output logic              left_b_o,
  output logic              right_b_o,
  output kd_pkg::kd_node_t  node_o      // Readback of the stored word
);

  // Pick the coordinate named by the split dimension
  function automatic logic [kd_pkg::KD_COORD_W-1:0] pick_coord(
    input kd_pkg::kd_patch_t patch,
    input logic [2:0]        dim
  );
    logic [kd_pkg::KD_COORD_W-1:0] c;
    c = '0;  // Illegal dimensions compare as coordinate zero
    if (dim < kd_pkg::KD_DIMS) begin
      c = patch.coord[dim];
    end
    return c;
  endfunction

  kd_pkg::kd_node_t              node_q;
  logic [2:0]                    dim;
  logic [kd_pkg::KD_COORD_W-1:0] coord_a;
  logic [kd_pkg::KD_COORD_W-1:0] coord_b;
  logic                          go_right_a;
  logic                          go_right_b;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_q <= '0;
    end else if (wr_en_i) begin
      node_q <= wdata_i;
    end
  end

  assign dim     = node_q.split[2:0];
  assign coord_a = pick_coord(patch_a_i, dim);
  assign coord_b = pick_coord(patch_b_i, dim);

  // Equal to the median goes right
  assign go_right_a = (coord_a >= node_q.median);
  assign go_right_b = (coord_b >= node_q.median);

  assign left_a_o  = valid_a_i & ~go_right_a;
  assign right_a_o = valid_a_i &  go_right_a;
  assign left_b_o  = valid_b_i & ~go_right_b;
  assign right_b_o = valid_b_i &  go_right_b;

  assign node_o = node_q;

endmodule

// ==== verilog/kd_node_tree.sv ====
//////////////////////////////////////////////////
// KD-tree node array, 63 nodes in six levels
// Pipelines patches and one-hot valids per level,
// decodes node writes and encodes the leaf index
//////////////////////////////////////////////////

module kd_node_tree (
  input  logic                                clk,
  input  logic                                rst_n,
  input  kd_pkg::kd_node_wr_t                 node_wr_i,
  input  kd_pkg::kd_query_t                   query_a_i,
  input  kd_pkg::kd_query_t                   query_b_i,
  input  logic [kd_pkg::KD_ADDR_W-1:0]        node_rd_addr_i,
  output kd_pkg::kd_node_t                    node_rd_o,
  output kd_pkg::kd_result_t                  result_a_o,
  output kd_pkg::kd_result_t                  result_b_o
);

  // One-hot leaf vector to index, valids are one-hot by construction
  function automatic kd_pkg::kd_result_t leaf_encode(
    input logic [kd_pkg::KD_LEAVES-1:0] vec
  );
    kd_pkg::kd_result_t res;
    res       = '0;
    res.valid = |vec;
    for (int k = 0; k < kd_pkg::KD_LEAVES; k++) begin
      if (vec[k]) begin
        res.leaf = res.leaf | k[kd_pkg::KD_ADDR_W-1:0];
      end
    end
    return res;
  endfunction

  // Stage s holds what level s-1 produced, low 2^s bits meaningful
  logic [kd_pkg::KD_LEAVES-1:0] stg_vld_a [1:kd_pkg::KD_DEPTH];
  logic [kd_pkg::KD_LEAVES-1:0] stg_vld_b [1:kd_pkg::KD_DEPTH];
  kd_pkg::kd_patch_t            stg_patch_a [1:kd_pkg::KD_DEPTH-1];  // Last level needs none
  kd_pkg::kd_patch_t            stg_patch_b [1:kd_pkg::KD_DEPTH-1];

  logic [kd_pkg::KD_NODES-1:0]  node_we;
  kd_pkg::kd_node_t             node_word [kd_pkg::KD_NODES];

  // Write address to a single node enable
  always_comb begin
    node_we = '0;
    if (node_wr_i.en && (node_wr_i.addr < kd_pkg::KD_NODES)) begin
      node_we[node_wr_i.addr] = 1'b1;
    end
  end

  genvar i, j;
  generate
    for (i = 0; i < kd_pkg::KD_DEPTH; i++) begin : g_level
      logic [kd_pkg::KD_LEAVES-1:0] vin_a;
      logic [kd_pkg::KD_LEAVES-1:0] vin_b;
      kd_pkg::kd_patch_t            pin_a;
      kd_pkg::kd_patch_t            pin_b;
      wire  [kd_pkg::KD_LEAVES-1:0] vout_a;   // Children of this level
      wire  [kd_pkg::KD_LEAVES-1:0] vout_b;

      if (i == 0) begin : g_root
        // Root sees the query straight from the inputs
        assign vin_a = {{(kd_pkg::KD_LEAVES-1){1'b0}}, query_a_i.valid};
        assign vin_b = {{(kd_pkg::KD_LEAVES-1){1'b0}}, query_b_i.valid};
        assign pin_a = query_a_i.patch;
        assign pin_b = query_b_i.patch;
      end else begin : g_inner
        assign vin_a = stg_vld_a[i];
        assign vin_b = stg_vld_b[i];
        assign pin_a = stg_patch_a[i];
        assign pin_b = stg_patch_b[i];
      end

      for (j = 0; j < 2**i; j++) begin : g_node
        localparam int NODE = 2**i - 1 + j;  // Heap address

        kd_internal_node i_kd_internal_node (
          .clk       (clk),
          .rst_n     (rst_n),
          .wr_en_i   (node_we[NODE]),
          .wdata_i   (node_wr_i.node),
          .valid_a_i (vin_a[j]),
          .valid_b_i (vin_b[j]),
          .patch_a_i (pin_a),
          .patch_b_i (pin_b),
          .left_a_o  (vout_a[2*j]),
          .right_a_o (vout_a[2*j+1]),
          .left_b_o  (vout_b[2*j]),
          .right_b_o (vout_b[2*j+1]),
          .node_o    (node_word[NODE])
        );
      end

      // Positions past this level's children stay empty
      if (i < kd_pkg::KD_DEPTH-1) begin : g_pad
        assign vout_a[kd_pkg::KD_LEAVES-1:2**(i+1)] = '0;
        assign vout_b[kd_pkg::KD_LEAVES-1:2**(i+1)] = '0;
      end

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          stg_vld_a[i+1] <= '0;
          stg_vld_b[i+1] <= '0;
        end else begin
          stg_vld_a[i+1] <= vout_a;
          stg_vld_b[i+1] <= vout_b;
        end
      end

      if (i < kd_pkg::KD_DEPTH-1) begin : g_patch
        always_ff @(posedge clk) begin
          stg_patch_a[i+1] <= pin_a;  // Payload travels with its valid
          stg_patch_b[i+1] <= pin_b;
        end
      end
    end
  endgenerate

  // Final stage, one-hot over 64 leaves
  assign result_a_o = leaf_encode(stg_vld_a[kd_pkg::KD_DEPTH]);
  assign result_b_o = leaf_encode(stg_vld_b[kd_pkg::KD_DEPTH]);

  // Readback mux, address 63 is not a node
  always_comb begin
    node_rd_o = '0;
    if (node_rd_addr_i < kd_pkg::KD_NODES) begin
      node_rd_o = node_word[node_rd_addr_i];
    end
  end

endmodule

// ==== verilog/kd_pkg.sv ====
//////////////////////////////////////////////////
// KD-tree search core shared definitions
// Tree sizes, patch and node words, query and
// result bundles, node write bundle, bus half select
//////////////////////////////////////////////////

package kd_pkg;

  localparam int KD_DIMS    = 5;   // Coordinates per patch
  localparam int KD_COORD_W = 11;  // Bits per coordinate
  localparam int KD_PATCH_W = KD_DIMS * KD_COORD_W;  // 55
  localparam int KD_DEPTH   = 6;   // Tree levels, also search latency
  localparam int KD_NODES   = 63;  // Internal nodes, heap order
  localparam int KD_LEAVES  = 64;
  localparam int KD_ADDR_W  = 6;   // Node address and leaf index width

  // Query patch, coordinate 0 sits in the low bits
  typedef struct packed {
    logic [KD_DIMS-1:0][KD_COORD_W-1:0] coord;
  } kd_patch_t;

  // Node word, split dimension in the high half
  typedef struct packed {
    logic [KD_COORD_W-1:0] split;   // Only [2:0] used, legal 0..4
    logic [KD_COORD_W-1:0] median;
  } kd_node_t;

  typedef struct packed {
    logic      valid;
    kd_patch_t patch;
  } kd_query_t;

  // One node update per cycle into the tree
  typedef struct packed {
    logic                 en;
    logic [KD_ADDR_W-1:0] addr;
    kd_node_t             node;
  } kd_node_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [KD_ADDR_W-1:0] leaf;   // Root decision in the MSB
  } kd_result_t;

  // Bus address bit 6
  typedef enum logic {
    KD_HALF_MEDIAN = 1'b0,
    KD_HALF_SPLIT  = 1'b1
  } kd_half_e;

endpackage

// ==== verilog/kd_search_top.sv ====
//////////////////////////////////////////////////
// KD-tree search core top level
// Configuration port plus the two-lane node tree
//////////////////////////////////////////////////

module kd_search_top (
  input  logic                clk,
  input  logic                rst_n,
  // Stream load
  input  logic                load_valid_i,
  input  kd_pkg::kd_node_t    load_data_i,
  // Register bus
  input  logic                bus_cyc_i,
  input  logic                bus_stb_i,
  input  logic                bus_we_i,
  input  logic [6:0]          bus_adr_i,
  input  logic [31:0]         bus_dat_i,
  output logic                bus_ack_o,
  output logic [31:0]         bus_dat_o,
  // Query lanes
  input  kd_pkg::kd_query_t   query_a_i,
  input  kd_pkg::kd_query_t   query_b_i,
  output kd_pkg::kd_result_t  result_a_o,
  output kd_pkg::kd_result_t  result_b_o
);

  kd_pkg::kd_node_wr_t          node_wr;
  logic [kd_pkg::KD_ADDR_W-1:0] node_rd_addr;
  kd_pkg::kd_node_t             node_rd;

  kd_cfg_port i_kd_cfg_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_valid_i   (load_valid_i),
    .load_data_i    (load_data_i),
    .bus_cyc_i      (bus_cyc_i),
    .bus_stb_i      (bus_stb_i),
    .bus_we_i       (bus_we_i),
    .bus_adr_i      (bus_adr_i),
    .bus_dat_i      (bus_dat_i),
    .bus_ack_o      (bus_ack_o),
    .bus_dat_o      (bus_dat_o),
    .node_wr_o      (node_wr),
    .node_rd_addr_o (node_rd_addr),
    .node_rd_i      (node_rd)
  );

  // Queries go straight in, results straight out
  kd_node_tree i_kd_node_tree (
    .clk            (clk),
    .rst_n          (rst_n),
    .node_wr_i      (node_wr),
    .query_a_i      (query_a_i),
    .query_b_i      (query_b_i),
    .node_rd_addr_i (node_rd_addr),
    .node_rd_o      (node_rd),
    .result_a_o     (result_a_o),
    .result_b_o     (result_b_o)
  );

endmodule
